/* Makefile */
TOP = tb_rv_cpu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // request toward the word memory, 66 bits
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } bus_req_t;

    // read response, one cycle after acceptance
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;

    // alu funct3, add and sub share one code
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] funct7_alt = 7'b0100000; // sub in register form

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read through the view its opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic [2:0]  funct3;
    } decoded_t;

endpackage

`default_nettype wire

/* compile.f */
common/isa_pkg.sv
common/bus_pkg.sv
core/instr_decoder.sv
core/alu.sv
core/register_file.sv
core/core_sequencer.sv
rtl/bus_controller.sv
rtl/rv_cpu_top.sv
verification/tb_memory_model.sv
verification/tb_rv_cpu_top.sv

/* core/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isa_pkg::decoded_t dec_i,
    input  logic [31:0]       a_i,
    input  logic [31:0]       b_i,
    input  logic [31:0]       pc_i,
    output logic [31:0]       result_o,
    output logic              take_o
);

    logic [31:0] opb;
    logic [31:0] op_result;
    logic [31:0] jalr_sum;
    logic        cond;

    assign opb      = dec_i.use_imm ? dec_i.imm : b_i;
    assign jalr_sum = a_i + dec_i.imm;

    // plain alu path, loads and stores land here as add with imm
    always_comb begin
        case (dec_i.alu_op)
            isa_pkg::alu_add:    op_result = a_i + opb;
            isa_pkg::alu_sub:    op_result = a_i - opb;
            isa_pkg::alu_xor:    op_result = a_i ^ opb;
            isa_pkg::alu_or:     op_result = a_i | opb;
            isa_pkg::alu_and:    op_result = a_i & opb;
            isa_pkg::alu_sll:    op_result = a_i << opb[4:0];
            isa_pkg::alu_srl:    op_result = a_i >> opb[4:0];
            isa_pkg::alu_pass_b: op_result = opb;
            default:             op_result = '0;
        endcase
    end

    // branch condition, always on the two registers
    always_comb begin
        case (dec_i.funct3)
            isa_pkg::f3_beq: cond = (a_i == b_i);
            isa_pkg::f3_bne: cond = (a_i != b_i);
            isa_pkg::f3_blt: cond = ($signed(a_i) < $signed(b_i));
            isa_pkg::f3_bge: cond = ($signed(a_i) >= $signed(b_i));
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        if (dec_i.is_branch || dec_i.is_jal) begin
            result_o = pc_i + dec_i.imm; // pc relative target
        end else if (dec_i.is_jalr) begin
            result_o = {jalr_sum[31:1], 1'b0};
        end else begin
            result_o = op_result;
        end
    end

    assign take_o = dec_i.is_jal | dec_i.is_jalr | (dec_i.is_branch & cond);

endmodule

`default_nettype wire

/* core/core_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module core_sequencer #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  isa_pkg::decoded_t dec_i,
    input  logic [31:0]       result_i,
    input  logic              take_i,
    input  logic [31:0]       rs2_data_i,
    input  logic              done_i,
    input  logic [31:0]       rdata_i,
    output isa_pkg::instr_u   instr_o,
    output logic [31:0]       pc_o,
    output bus_pkg::bus_req_t cmd_o,
    output logic              wr_en_o,
    output logic [31:0]       wr_data_o
);

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_execute,
        st_mem,
        st_mem_wait
    } state_t;

    state_t          state_q;
    state_t          state_d;
    logic [31:0]     pc_q;
    isa_pkg::instr_u instr_q;
    logic [31:0]     pc_plus4;
    logic            mem_op;
    logic            pc_update;

    assign pc_plus4 = pc_q + 32'd4;
    assign mem_op   = dec_i.mem_read | dec_i.mem_write;

    always_comb begin
        state_d = state_q;
        cmd_o   = '0;
        case (state_q)
            st_fetch: begin
                cmd_o.valid = 1'b1; // one cycle pulse
                cmd_o.addr  = pc_q;
                state_d     = st_fetch_wait;
            end
            st_fetch_wait: begin
                if (done_i) state_d = st_execute;
            end
            st_execute: begin
                if (mem_op) begin
                    cmd_o.valid = 1'b1;
                    cmd_o.write = dec_i.mem_write;
                    cmd_o.addr  = result_i;
                    cmd_o.wdata = rs2_data_i;
                    state_d     = st_mem;
                end else begin
                    state_d = st_fetch;
                end
            end
            st_mem: state_d = st_mem_wait; // request sits in the bus controller
            st_mem_wait: begin
                if (done_i) state_d = st_fetch;
            end
            default: state_d = st_fetch;
        endcase
    end

    // alu and jumps retire on execute, memory ops on done
    assign pc_update = (state_q == st_execute && !mem_op) ||
                       (state_q == st_mem_wait && done_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_fetch;
            pc_q    <= reset_pc;
            instr_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_fetch_wait && done_i) begin
                instr_q <= rdata_i; // latch fetched word
            end
            if (pc_update) begin
                pc_q <= take_i ? result_i : pc_plus4;
            end
        end
    end

    assign wr_en_o = dec_i.reg_write &&
                     ((state_q == st_execute && !dec_i.mem_read) ||
                      (state_q == st_mem_wait && done_i && dec_i.mem_read));

    always_comb begin
        if (dec_i.mem_read) begin
            wr_data_o = rdata_i;
        end else if (dec_i.is_jal || dec_i.is_jalr) begin
            wr_data_o = pc_plus4; // link
        end else begin
            wr_data_o = result_i;
        end
    end

    assign instr_o = instr_q;
    assign pc_o    = pc_q;

endmodule

`default_nettype wire

/* core/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  isa_pkg::instr_u   instr_i,
    output isa_pkg::decoded_t dec_o
);

    // funct3 to alu op, alt only matters for the register form
    function automatic isa_pkg::alu_op_t map_alu(input logic [2:0] f3, input logic alt);
        isa_pkg::alu_op_t op;
        case (f3)
            isa_pkg::f3_add: op = alt ? isa_pkg::alu_sub : isa_pkg::alu_add;
            isa_pkg::f3_sll: op = isa_pkg::alu_sll;
            isa_pkg::f3_xor: op = isa_pkg::alu_xor;
            isa_pkg::f3_srl: op = isa_pkg::alu_srl;
            isa_pkg::f3_or:  op = isa_pkg::alu_or;
            isa_pkg::f3_and: op = isa_pkg::alu_and;
            default:         op = isa_pkg::alu_add;
        endcase
        return op;
    endfunction

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u = {instr_i.u.imm, 12'b0};
    assign imm_j = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    always_comb begin
        dec_o = '0; // unknown opcode: no write, no access
        dec_o.alu_op = isa_pkg::alu_add;
        case (instr_i.r.opcode)
            isa_pkg::op_alu_reg: begin
                dec_o.rd        = instr_i.r.rd;
                dec_o.rs1       = instr_i.r.rs1;
                dec_o.rs2       = instr_i.r.rs2;
                dec_o.funct3    = instr_i.r.funct3;
                dec_o.alu_op    = map_alu(instr_i.r.funct3,
                                          instr_i.r.funct7 == isa_pkg::funct7_alt);
                dec_o.reg_write = 1'b1;
            end
            isa_pkg::op_alu_imm, isa_pkg::op_load, isa_pkg::op_jalr: begin
                dec_o.rd        = instr_i.i.rd;
                dec_o.rs1       = instr_i.i.rs1;
                dec_o.funct3    = instr_i.i.funct3;
                dec_o.imm       = imm_i;
                dec_o.use_imm   = 1'b1;
                dec_o.reg_write = 1'b1;
                if (instr_i.i.opcode == isa_pkg::op_alu_imm) begin
                    dec_o.alu_op = map_alu(instr_i.i.funct3, 1'b0);
                end
                dec_o.mem_read = (instr_i.i.opcode == isa_pkg::op_load);
                dec_o.is_jalr  = (instr_i.i.opcode == isa_pkg::op_jalr);
            end
            isa_pkg::op_store: begin
                dec_o.rs1       = instr_i.s.rs1;
                dec_o.rs2       = instr_i.s.rs2;
                dec_o.imm       = imm_s;
                dec_o.use_imm   = 1'b1; // address is rs1 + imm
                dec_o.mem_write = 1'b1;
            end
            isa_pkg::op_branch: begin
                dec_o.rs1       = instr_i.b.rs1;
                dec_o.rs2       = instr_i.b.rs2;
                dec_o.funct3    = instr_i.b.funct3;
                dec_o.imm       = imm_b;
                dec_o.is_branch = 1'b1;
            end
            isa_pkg::op_lui: begin
                dec_o.rd        = instr_i.u.rd;
                dec_o.imm       = imm_u;
                dec_o.use_imm   = 1'b1;
                dec_o.alu_op    = isa_pkg::alu_pass_b;
                dec_o.reg_write = 1'b1;
            end
            isa_pkg::op_jal: begin
                dec_o.rd        = instr_i.j.rd;
                dec_o.imm       = imm_j;
                dec_o.is_jal    = 1'b1;
                dec_o.reg_write = 1'b1; // link pc+4
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* core/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        wr_en_i,
    input  logic [31:0] wr_data_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [1:31]; // no storage behind x0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en_i && rd_i != 5'd0) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    // asynchronous read ports
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* rtl/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  bus_pkg::bus_req_t          cmd_i,
    input  bus_pkg::bus_rsp_t          mem_rsp_i,
    input  logic                       mem_full_i,
    output bus_pkg::bus_req_t          mem_req_o,
    output logic                       done_o,
    output logic [bus_pkg::data_w-1:0] rdata_o
);

    bus_pkg::bus_req_t req_q;
    logic              accept;
    logic              wait_q;       // accepted, waiting for the finish
    logic              wait_write_q;

    assign accept = req_q.valid & ~mem_full_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q        <= '0;
            wait_q       <= 1'b0;
            wait_write_q <= 1'b0;
        end else begin
            if (cmd_i.valid) begin
                req_q <= cmd_i;
            end else if (accept) begin
                req_q.valid <= 1'b0;
            end
            if (accept) begin
                wait_q       <= 1'b1;
                wait_write_q <= req_q.write;
            end else if (done_o) begin
                wait_q <= 1'b0;
            end
        end
    end

    // reads finish with the response, writes one cycle after acceptance
    assign done_o    = wait_q & (wait_write_q | mem_rsp_i.valid);
    assign rdata_o   = mem_rsp_i.rdata;
    assign mem_req_o = req_q; // held stable under mem_full_i

endmodule

`default_nettype wire

/* rtl/rv_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_cpu_top #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    output bus_pkg::bus_req_t mem_req_o,
    input  bus_pkg::bus_rsp_t mem_rsp_i,
    input  logic              mem_full_i
);

    isa_pkg::instr_u   instr;
    isa_pkg::decoded_t dec;
    bus_pkg::bus_req_t cmd;
    logic [31:0]       pc;
    logic [31:0]       result;
    logic              take;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic              done;
    logic [31:0]       rdata;
    logic              wr_en;
    logic [31:0]       wr_data;

    core_sequencer #(
        .reset_pc(reset_pc)
    ) i_core_sequencer (
        .clk       (clk),
        .rst       (rst),
        .dec_i     (dec),
        .result_i  (result),
        .take_i    (take),
        .rs2_data_i(rs2_data),
        .done_i    (done),
        .rdata_i   (rdata),
        .instr_o   (instr),
        .pc_o      (pc),
        .cmd_o     (cmd),
        .wr_en_o   (wr_en),
        .wr_data_o (wr_data)
    );

    instr_decoder i_instr_decoder (
        .instr_i(instr),
        .dec_o  (dec)
    );

    register_file i_register_file (
        .clk       (clk),
        .rst       (rst),
        .rs1_i     (dec.rs1),
        .rs2_i     (dec.rs2),
        .rd_i      (dec.rd),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    alu i_alu (
        .dec_i   (dec),
        .a_i     (rs1_data),
        .b_i     (rs2_data),
        .pc_i    (pc),
        .result_o(result),
        .take_o  (take)
    );

    bus_controller i_bus_controller (
        .clk       (clk),
        .rst       (rst),
        .cmd_i     (cmd),
        .mem_rsp_i (mem_rsp_i),
        .mem_full_i(mem_full_i),
        .mem_req_o (mem_req_o),
        .done_o    (done),
        .rdata_o   (rdata)
    );

endmodule

`default_nettype wire

/* verification/tb_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              bp_en_i,
    input  bus_pkg::bus_req_t req_i,
    output bus_pkg::bus_rsp_t rsp_o,
    output logic              full_o
);

    logic [31:0]       mem [0:255]; // 1 KB word memory
    bus_pkg::bus_rsp_t rsp_q = '0;
    logic              full_q = 1'b0;
    integer            seed = 32'h5b7b_2c75;
    logic              accept;

    assign accept = req_i.valid && !full_q;

    always @(posedge clk) begin
        if (rst) begin
            rsp_q  <= '0;
            full_q <= 1'b0;
        end else begin
            rsp_q.valid <= accept && !req_i.write; // reads answer one cycle later
            if (accept && !req_i.write) begin
                rsp_q.rdata <= mem[req_i.addr[9:2]];
            end
            if (accept && req_i.write) begin
                mem[req_i.addr[9:2]] = req_i.wdata;
            end
            // about half the cycles are busy when enabled
            full_q <= bp_en_i && (($random(seed) & 1) != 0);
        end
    end

    // preload of program and data
    task load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[9:2]] = data;
    endtask

    assign rsp_o  = rsp_q;
    assign full_o = full_q;

endmodule

`default_nettype wire

/* verification/tb_rv_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_cpu_top;

    localparam logic [31:0] reset_pc = 32'h0000_0100;
    localparam logic [31:0] preset   = 32'h1234_5678; // word read by the load test

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              bp_en = 1'b0;
    bus_pkg::bus_req_t mem_req;
    bus_pkg::bus_rsp_t mem_rsp;
    logic              mem_full;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];
    string       run_tag = "";
    int          store_idx = 0;
    int          test_errs = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic        timed_out = 1'b0;
    logic [31:0] park_pc = '0;
    logic        parked = 1'b0;

    always #5 clk = ~clk;

    rv_cpu_top #(
        .reset_pc(reset_pc)
    ) i_rv_cpu_top (
        .clk       (clk),
        .rst       (rst),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp),
        .mem_full_i(mem_full)
    );

    tb_memory_model i_tb_memory_model (
        .clk    (clk),
        .rst    (rst),
        .bp_en_i(bp_en),
        .req_i  (mem_req),
        .rsp_o  (mem_rsp),
        .full_o (mem_full)
    );

    // instruction encoders for the base ISA formats
    function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] imm_op(input int op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sw_op(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] branch_op(input int f3, input int rs1, input int rs2,
                                              input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] lui_op(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] jal_op(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic branch_taken(input int f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            0: return x == y;
            1: return x != y;
            4: return $signed(x) < $signed(y);
            default: return $signed(x) >= $signed(y);
        endcase
    endfunction

    function automatic logic [31:0] next_pc();
        return reset_pc + 32'(4 * prog.size());
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // sw rs2 to base x10 + off and record the store it must produce
    task automatic store_and_expect(input int rs2, input int off, input logic [31:0] value,
                                    input string name);
        emit(sw_op(rs2, 10, off));
        exp_addr.push_back(32'h300 + off);
        exp_data.push_back(value);
        exp_name.push_back(name);
    endtask

    // branch over a marker store that shows only on fall through
    task automatic branch_case(input int f3, input int rs1, input int rs2,
                               input logic [31:0] x, input logic [31:0] y, input int k);
        emit(imm_op('h13, 0, 14, 0, k));
        emit(branch_op(f3, rs1, rs2, 8));
        if (branch_taken(f3, x, y)) begin
            emit(sw_op(14, 10, 40 + 4 * k));
        end else begin
            store_and_expect(14, 40 + 4 * k, k, "branch");
        end
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        a = 32'h0000_05a3;
        b = 32'hffff_ffd4; // -44
        emit(imm_op('h13, 0, 10, 0, 'h300)); // store base
        emit(imm_op('h13, 0, 1, 0, a));
        emit(imm_op('h13, 0, 2, 0, b));
        emit(reg_op(0, 0, 3, 1, 2));
        emit(reg_op('h20, 0, 4, 1, 2));
        emit(reg_op(0, 4, 5, 1, 2));
        emit(reg_op(0, 6, 6, 1, 2));
        emit(reg_op(0, 7, 7, 1, 2));
        emit(imm_op('h13, 0, 9, 0, 5));
        emit(reg_op(0, 1, 8, 1, 9));
        emit(reg_op(0, 5, 11, 2, 9)); // logical shift of a negative value
        emit(lui_op(12, 'habcde));
        store_and_expect(1, 0, a, "alu");
        store_and_expect(3, 4, a + b, "alu");
        store_and_expect(4, 8, a - b, "alu");
        store_and_expect(5, 12, a ^ b, "alu");
        store_and_expect(6, 16, a | b, "alu");
        store_and_expect(7, 20, a & b, "alu");
        store_and_expect(8, 24, a << 5, "alu");
        store_and_expect(11, 28, b >> 5, "alu");
        store_and_expect(12, 32, 32'habcde000, "alu");
        emit(imm_op('h13, 0, 0, 0, 'h123));
        store_and_expect(0, 36, 32'h0, "x0");
        emit(imm_op('h03, 2, 13, 10, -128)); // lw from 0x280
        emit(imm_op('h13, 0, 13, 13, 1));
        store_and_expect(13, 40, preset + 1, "load");
        branch_case(0, 1, 1, a, a, 1);
        branch_case(0, 1, 2, a, b, 2);
        branch_case(1, 1, 2, a, b, 3);
        branch_case(1, 1, 1, a, a, 4);
        branch_case(4, 2, 1, b, a, 5);
        branch_case(4, 1, 2, a, b, 6);
        branch_case(5, 1, 2, a, b, 7);
        branch_case(5, 2, 1, b, a, 8);
        p = next_pc();
        emit(jal_op(15, 8));
        emit(sw_op(15, 10, 100)); // skipped by the jal
        store_and_expect(15, 76, p + 4, "jump");
        p = next_pc();
        emit(imm_op('h13, 0, 16, 0, p + 9)); // odd sum gets bit 0 cleared
        emit(imm_op('h67, 0, 17, 16, 4));
        emit(sw_op(17, 10, 104));
        store_and_expect(17, 80, p + 8, "jump");
        park_pc = next_pc();
        emit(jal_op(0, 0)); // park
    endtask

    task automatic load_image();
        for (int k = 0; k < 256; k++) begin
            i_tb_memory_model.load_word(32'(k * 4), 32'h5a5a_0000 ^ 32'(k * 257));
        end
        foreach (prog[i]) begin
            i_tb_memory_model.load_word(reset_pc + 32'(i * 4), prog[i]);
        end
        i_tb_memory_model.load_word(32'h280, preset);
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        store_expected: assert (store_idx < exp_addr.size())
        else begin
            $display("unexpected store of %h to %h after the last expected one", data, addr);
            errors++;
        end
        if (store_idx < exp_addr.size()) begin
            checks++;
            store_match: assert (addr == exp_addr[store_idx] && data == exp_data[store_idx])
            else begin
                $display("[FAIL] %s%s: expected %h at %h, actual %h at %h", run_tag,
                         exp_name[store_idx], exp_data[store_idx], exp_addr[store_idx],
                         data, addr);
                errors++;
                test_errs++;
            end
            // last store of a test ends it
            if (store_idx + 1 == exp_addr.size() ||
                exp_name[store_idx + 1] != exp_name[store_idx]) begin
                if (test_errs == 0) begin
                    $display("[PASS] %s%s", run_tag, exp_name[store_idx]);
                    tests_ok++;
                end else begin
                    $display("[FAIL] %s%s: %0d wrong stores", run_tag, exp_name[store_idx],
                             test_errs);
                    tests_bad++;
                end
                test_errs = 0;
            end
            store_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && mem_req.valid && !mem_full) begin
            if (mem_req.write) begin
                check_store(mem_req.addr, mem_req.wdata);
            end else if (mem_req.addr == park_pc) begin
                parked = 1'b1; // fetch of the final jal
            end
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && mem_full) |=> $stable(mem_req))
    else begin
        $display("bus request changed while mem_full_i was high at %0t", $time);
        errors++;
    end

    task automatic run_program(input logic bp, input string tag);
        int limit;
        int cycles;
        limit = prog.size() * 6 * 4 + 200; // 6 cycles per op times 4 for back-pressure
        cycles = 0;
        run_tag = tag;
        store_idx = 0;
        test_errs = 0;
        @(posedge clk);
        rst <= 1'b1;
        bp_en <= bp;
        repeat (8) @(posedge clk);
        parked = 1'b0;
        rst <= 1'b0;
        while (!parked && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!parked) begin
            $display("timeout: park loop not reached after %0d cycles, %0d of %0d stores seen",
                     cycles, store_idx, exp_addr.size());
            timed_out = 1'b1;
        end else begin
            all_stores: assert (store_idx == exp_addr.size())
            else begin
                $display("%sonly %0d of %0d expected stores appeared before the park loop",
                         run_tag, store_idx, exp_addr.size());
                errors++;
            end
        end
    endtask

    task automatic summarize();
        $display("%0d tests passed, %0d tests failed, %0d stores checked, %0d errors",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0 && tests_bad == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        build_program();
        load_image();
        run_program(1'b0, "");
        if (!timed_out) begin
            run_program(1'b1, "backpressure/"); // same table under random mem_full_i
        end
        summarize();
    end

endmodule

`default_nettype wire
